// ==== Bender.yml ====
package:
  name: elevator

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - elevator_pkg.sv
      - call_if.sv
      - car_if.sv
      - call_store.sv
      - car_position.sv
      - dispatcher.sv
      - elevator_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_elevator.sv

// ==== call_if.sv ====
// pending calls and clear pulses
`timescale 1ns/1ns
`default_nettype none

interface call_if;

	elevator_pkg::floor_mask_t pending_cab;  // cab buttons
	elevator_pkg::floor_mask_t pending_up;   // hall up buttons
	elevator_pkg::floor_mask_t pending_down; // hall down buttons
	elevator_pkg::floor_t      clear_floor;  // floor being served
	logic                      clear_cab;
	logic                      clear_up;
	logic                      clear_down;

	modport store (
		output pending_cab, pending_up, pending_down,
		input  clear_floor, clear_cab, clear_up, clear_down
	);

	modport dispatch (
		input  pending_cab, pending_up, pending_down,
		output clear_floor, clear_cab, clear_up, clear_down
	);

endinterface

`default_nettype wire

// ==== call_store.sv ====
// cab and hall call latches
`timescale 1ns/1ns
`default_nettype none

`include "elevator_consts.svh"

module call_store (
	input  wire                            clk,
	input  wire                            reset,
	input  wire elevator_pkg::floor_mask_t btn_in,
	input  wire elevator_pkg::floor_mask_t btn_up_out,
	input  wire elevator_pkg::floor_mask_t btn_down_out,
	call_if.store                          calls
);

	// hall buttons that exist in the shaft
	localparam elevator_pkg::floor_mask_t up_valid =
		~(elevator_pkg::floor_mask_t'(1) << (`ELEV_FLOORS - 1));
	localparam elevator_pkg::floor_mask_t down_valid = ~elevator_pkg::floor_mask_t'(1);

	elevator_pkg::floor_mask_t clr_onehot;
	elevator_pkg::floor_mask_t cab_clr;
	elevator_pkg::floor_mask_t up_clr;
	elevator_pkg::floor_mask_t down_clr;

	assign clr_onehot = elevator_pkg::floor_mask_t'(1) << calls.clear_floor;
	assign cab_clr    = {`ELEV_FLOORS{calls.clear_cab}} & clr_onehot;
	assign up_clr     = {`ELEV_FLOORS{calls.clear_up}} & clr_onehot;
	assign down_clr   = {`ELEV_FLOORS{calls.clear_down}} & clr_onehot;

	// a pressed button outranks a clear on the same edge
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			calls.pending_cab  <= '0;
			calls.pending_up   <= '0;
			calls.pending_down <= '0;
		end else begin
			calls.pending_cab  <= (calls.pending_cab & ~cab_clr) | btn_in;
			calls.pending_up   <= (calls.pending_up & ~up_clr) | (btn_up_out & up_valid);
			calls.pending_down <= (calls.pending_down & ~down_clr) |
				(btn_down_out & down_valid);
		end
	end

	a_no_phantom_hall: assert property (
		@(posedge clk) disable iff (!reset)
		!calls.pending_up[`ELEV_FLOORS-1] && !calls.pending_down[0]
	) else $error("hall call latched at a floor without that button");

endmodule

`default_nettype wire

// ==== car_if.sv ====
// car step pulses and position
`timescale 1ns/1ns
`default_nettype none

interface car_if;

	logic                 step;     // one half floor moved
	logic                 step_up;  // direction of that step
	elevator_pkg::floor_t floor;    // last full floor reached
	logic                 at_floor; // standing at a full floor

	modport position (
		input  step, step_up,
		output floor, at_floor
	);

	modport dispatch (
		output step, step_up,
		input  floor, at_floor
	);

endinterface

`default_nettype wire

// ==== car_position.sv ====
// car position tracker
`timescale 1ns/1ns
`default_nettype none

`include "elevator_consts.svh"

module car_position (
	input  wire                  clk,
	input  wire                  reset,
	car_if.position              car,
	output elevator_pkg::floor_t level_display
);

	logic travel_up; // direction of the half floor in progress

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			car.floor    <= '0;
			car.at_floor <= 1'b1;
			travel_up    <= 1'b1;
		end else if (car.step) begin
			travel_up <= car.step_up;
			if (car.at_floor) begin
				car.at_floor <= 1'b0; // floor kept until arrival
			end else begin
				car.at_floor <= 1'b1;
				car.floor    <= travel_up ? car.floor + elevator_pkg::floor_t'(1)
				                          : car.floor - elevator_pkg::floor_t'(1);
			end
		end
	end

	assign level_display = car.floor;

	a_top_bound: assert property (
		@(posedge clk) disable iff (!reset)
		car.step && car.step_up && car.at_floor |-> car.floor != (`ELEV_FLOORS - 1)
	) else $error("car stepped above the top floor");

	a_bottom_bound: assert property (
		@(posedge clk) disable iff (!reset)
		car.step && !car.step_up && car.at_floor |-> car.floor != '0
	) else $error("car stepped below floor zero");

	// no turning around between two floors
	a_no_midway_reverse: assert property (
		@(posedge clk) disable iff (!reset)
		car.step && !car.at_floor |-> car.step_up == travel_up
	) else $error("car reversed between floors");

endmodule

`default_nettype wire

// ==== dispatcher.sv ====
// elevator dispatcher FSM
`timescale 1ns/1ns
`default_nettype none

`include "elevator_consts.svh"

module dispatcher (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         open_btn,
	input  wire                         close_btn,
	call_if.dispatch                    calls,
	car_if.dispatch                     car,
	output elevator_pkg::engine_code_t  engine,
	output elevator_pkg::door_code_t    door
);

	localparam logic [2:0] half_last  = 3'(`HALF_FLOOR_CYCLES - 1);
	localparam logic [2:0] dwell_last = 3'(`DOOR_DWELL_CYCLES - 1);
	localparam logic [2:0] close_last = 3'(`DOOR_CLOSE_CYCLES - 1);

	elevator_pkg::disp_state_t state;
	logic                      dir_up; // travel direction kept while calls ahead
	logic [2:0]                phase;  // half floor, dwell or closing counter

	elevator_pkg::floor_mask_t all_calls;
	elevator_pkg::floor_mask_t hall_calls;
	elevator_pkg::floor_mask_t here_mask;
	elevator_pkg::floor_mask_t below_mask;
	elevator_pkg::floor_mask_t above_mask;

	logic calls_above;
	logic calls_below;
	logic calls_ahead;
	logic calls_behind;
	logic serve_here;
	logic decide;
	logic stop_now;
	logic halt_now;
	logic running;
	logic door_is_open;

	// masks relative to the car
	assign here_mask  = elevator_pkg::floor_mask_t'(1) << car.floor;
	assign below_mask = here_mask - elevator_pkg::floor_mask_t'(1);
	assign above_mask = ~(below_mask | here_mask);

	assign hall_calls   = calls.pending_up | calls.pending_down;
	assign all_calls    = calls.pending_cab | hall_calls;
	assign calls_above  = |(all_calls & above_mask);
	assign calls_below  = |(all_calls & below_mask);
	assign calls_ahead  = dir_up ? calls_above : calls_below;
	assign calls_behind = dir_up ? calls_below : calls_above;

	// directional collective rule
	assign serve_here = |(calls.pending_cab & here_mask) |
		|((dir_up ? calls.pending_up : calls.pending_down) & here_mask) |
		(!calls_ahead && |(hall_calls & here_mask));

	// first cycle at a full floor while moving
	assign decide   = (state == elevator_pkg::st_moving) && car.at_floor && (phase == '0);
	assign stop_now = decide && serve_here;
	assign halt_now = decide && !serve_here && !calls_ahead; // nothing left that way
	assign running  = (state == elevator_pkg::st_moving) && !stop_now && !halt_now;

	assign door_is_open = (state == elevator_pkg::st_door_open) || stop_now;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= elevator_pkg::st_parked;
			dir_up <= 1'b1;
			phase  <= '0;
		end else begin
			case (state)
				elevator_pkg::st_parked: begin
					phase <= '0;
					if (serve_here || open_btn) begin
						state <= elevator_pkg::st_door_open;
					end else if (calls_ahead) begin
						state <= elevator_pkg::st_moving;
					end else if (calls_behind) begin
						state  <= elevator_pkg::st_moving;
						dir_up <= !dir_up; // turn around
					end
				end
				elevator_pkg::st_moving: begin
					if (stop_now) begin
						state <= elevator_pkg::st_door_open;
						phase <= 3'd1; // arrival cycle already showed open
					end else if (halt_now) begin
						state <= elevator_pkg::st_parked;
						phase <= '0;
					end else if (phase == half_last) begin
						phase <= '0;
					end else begin
						phase <= phase + 3'd1;
					end
				end
				elevator_pkg::st_door_open: begin
					if (close_btn || phase == dwell_last) begin
						state <= elevator_pkg::st_door_closing;
						phase <= '0;
					end else begin
						phase <= phase + 3'd1;
					end
				end
				elevator_pkg::st_door_closing: begin
					if (open_btn) begin
						state <= elevator_pkg::st_door_open; // fresh dwell
						phase <= '0;
					end else if (phase == close_last) begin
						state <= elevator_pkg::st_parked;
						phase <= '0;
					end else begin
						phase <= phase + 3'd1;
					end
				end
				default: begin
					state <= elevator_pkg::st_parked;
					phase <= '0;
				end
			endcase
		end
	end

	// half floor done at the last engine cycle
	assign car.step    = running && (phase == half_last);
	assign car.step_up = dir_up;

	// serve the floor while the door is open
	assign calls.clear_floor = car.floor;
	assign calls.clear_cab   = door_is_open;
	assign calls.clear_up    = door_is_open && (dir_up || !calls_ahead);
	assign calls.clear_down  = door_is_open && (!dir_up || !calls_ahead);

	assign engine = !running ? `ENGINE_IDLE :
	                dir_up   ? `ENGINE_UP   : `ENGINE_DOWN;

	assign door = door_is_open                             ? `DOOR_OPEN  :
	              (state == elevator_pkg::st_door_closing) ? `DOOR_CLOSE : `DOOR_IDLE;

	a_door_engine_excl: assert property (
		@(posedge clk) disable iff (!reset)
		door != `DOOR_IDLE |-> engine == `ENGINE_IDLE
	) else $error("door active while the engine runs");

endmodule

`default_nettype wire

// ==== elevator.f ====
+incdir+.
elevator_pkg.sv
call_if.sv
car_if.sv
call_store.sv
car_position.sv
dispatcher.sv
elevator_top.sv
tb_elevator.sv

// ==== elevator_consts.svh ====
// elevator controller constants
`ifndef ELEVATOR_CONSTS_SVH
`define ELEVATOR_CONSTS_SVH

// building size
`define ELEV_FLOORS       8
`define ELEV_FLOOR_BITS   3

// engine output codes
`define ENGINE_IDLE       2'd0
`define ENGINE_DOWN       2'd1
`define ENGINE_UP         2'd2

// door output codes
`define DOOR_IDLE         2'd0
`define DOOR_OPEN         2'd1
`define DOOR_CLOSE        2'd2

`define DOOR_DWELL_CYCLES 6   // door held open
`define DOOR_CLOSE_CYCLES 2   // door travel when closing
`define HALF_FLOOR_CYCLES 3   // engine time per half floor

`endif

// ==== elevator_pkg.sv ====
// elevator shared types
`default_nettype none

`include "elevator_consts.svh"

package elevator_pkg;

	typedef logic [`ELEV_FLOOR_BITS-1:0] floor_t;    // floor number
	typedef logic [`ELEV_FLOORS-1:0]     floor_mask_t; // one bit per floor

	typedef logic [1:0] engine_code_t; // idle, down, up
	typedef logic [1:0] door_code_t;   // idle, open, close

	// dispatcher FSM
	typedef enum logic [1:0] {
		st_parked,
		st_moving,
		st_door_open,
		st_door_closing
	} disp_state_t;

endpackage

`default_nettype wire

// ==== elevator_top.sv ====
// elevator controller top level
`timescale 1ns/1ns
`default_nettype none

module elevator_top (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            open_btn,
	input  wire                            close_btn,
	input  wire elevator_pkg::floor_mask_t btn_in,       // cab buttons
	input  wire elevator_pkg::floor_mask_t btn_up_out,   // hall up
	input  wire elevator_pkg::floor_mask_t btn_down_out, // hall down
	output elevator_pkg::engine_code_t     engine,
	output elevator_pkg::door_code_t       door,
	output elevator_pkg::floor_t           level_display
);

	call_if i_call_if();
	car_if  i_car_if();

	call_store i_call_store (
		.clk          (clk),
		.reset        (reset),
		.btn_in       (btn_in),
		.btn_up_out   (btn_up_out),
		.btn_down_out (btn_down_out),
		.calls        (i_call_if.store)
	);

	car_position i_car_position (
		.clk           (clk),
		.reset         (reset),
		.car           (i_car_if.position),
		.level_display (level_display)
	);

	dispatcher i_dispatcher (
		.clk       (clk),
		.reset     (reset),
		.open_btn  (open_btn),
		.close_btn (close_btn),
		.calls     (i_call_if.dispatch),
		.car       (i_car_if.dispatch),
		.engine    (engine),
		.door      (door)
	);

endmodule

`default_nettype wire

// ==== tb_elevator.sv ====
// elevator controller testbench
`timescale 1ns/1ns
`default_nettype none

`include "elevator_consts.svh"

module tb_elevator;

	localparam int SEQUENCES      = 80;
	localparam int RESET_CYCLES   = 16;
	localparam int CALL_AGE_LIMIT = 600; // cycles a call may wait for service

	logic                       clk;
	logic                       reset;
	logic                       open_btn;
	logic                       close_btn;
	elevator_pkg::floor_mask_t  btn_in;
	elevator_pkg::floor_mask_t  btn_up_out;
	elevator_pkg::floor_mask_t  btn_down_out;
	elevator_pkg::engine_code_t engine;
	elevator_pkg::door_code_t   door;
	elevator_pkg::floor_t       level_display;

	logic [15:0] lfsr;
	logic        no_press_yet;
	logic        quiet_phase;   // model and DUT both empty
	logic        invalid_stage; // only missing hall buttons pressed
	int          cab_age[`ELEV_FLOORS];
	int          up_age[`ELEV_FLOORS];
	int          down_age[`ELEV_FLOORS];
	int          oldest_call;
	logic        model_empty;
	int          open_run;
	int          close_run;
	int          open_wait;

	elevator_top i_elevator_top (
		.clk           (clk),
		.reset         (reset),
		.open_btn      (open_btn),
		.close_btn     (close_btn),
		.btn_in        (btn_in),
		.btn_up_out    (btn_up_out),
		.btn_down_out  (btn_down_out),
		.engine        (engine),
		.door          (door),
		.level_display (level_display)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	initial begin : watchdog
		repeat (SEQUENCES * 200) @(posedge clk);
		stop_run("timeout: the calls were not all served before the time limit");
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = (value << 1) | lfsr[0];
		end
	endtask

	function automatic int next_age(input int age, input logic press, input logic served);
		if (press && (age == 0 || served))
			return 1; // fresh call since a press outranks the clear
		if (served)
			return 0;
		return (age != 0) ? age + 1 : 0;
	endfunction

	// reference call model that ages every pending call
	always @(posedge clk or negedge reset) begin : call_model
		int   worst;
		int   nxt;
		logic served;
		worst = 0;
		if (!reset) begin
			for (int f = 0; f < `ELEV_FLOORS; f++) begin
				cab_age[f]  <= 0;
				up_age[f]   <= 0;
				down_age[f] <= 0;
			end
			oldest_call <= 0;
		end else begin
			for (int f = 0; f < `ELEV_FLOORS; f++) begin
				served = (door == `DOOR_OPEN) && (level_display == f) &&
					(engine == `ENGINE_IDLE);
				nxt = next_age(cab_age[f], btn_in[f], served);
				cab_age[f] <= nxt;
				if (nxt > worst) worst = nxt;
				nxt = next_age(up_age[f], btn_up_out[f] && f != `ELEV_FLOORS - 1, served);
				up_age[f] <= nxt;
				if (nxt > worst) worst = nxt;
				nxt = next_age(down_age[f], btn_down_out[f] && f != 0, served);
				down_age[f] <= nxt;
				if (nxt > worst) worst = nxt;
			end
			oldest_call <= worst;
		end
	end

	assign model_empty = (oldest_call == 0);

	always @(posedge clk or negedge reset) begin : door_runs
		if (!reset) begin
			open_run  <= 0;
			close_run <= 0;
			open_wait <= 0;
		end else begin
			open_run  <= (door == `DOOR_OPEN) ? open_run + 1 : 0;
			close_run <= (door == `DOOR_CLOSE) ? close_run + 1 : 0;
			if (door == `DOOR_OPEN)
				open_wait <= 0;
			else if (quiet_phase && open_btn)
				open_wait <= 1;
			else if (open_wait != 0)
				open_wait <= open_wait + 1;
		end
	end

	a_reset_state: assert property (@(posedge clk) disable iff (!reset)
		no_press_yet |-> engine == `ENGINE_IDLE && door == `DOOR_IDLE && level_display == 0)
		else stop_run($sformatf("Error at %0t ns: outputs not idle after reset", $time));
	a_call_served: assert property (@(posedge clk) disable iff (!reset)
		oldest_call < CALL_AGE_LIMIT)
		else stop_run($sformatf("Error at %0t ns: call not served in time", $time));
	a_door_engine: assert property (@(posedge clk) disable iff (!reset)
		door != `DOOR_IDLE |-> engine == `ENGINE_IDLE)
		else stop_run($sformatf("Error at %0t ns: door active while moving", $time));
	a_level_step: assert property (@(posedge clk) disable iff (!reset)
		level_display != $past(level_display) |->
		($past(engine) == `ENGINE_UP && level_display == $past(level_display) + 3'd1) ||
		($past(engine) == `ENGINE_DOWN && level_display == $past(level_display) - 3'd1))
		else stop_run($sformatf("Error at %0t ns: display jumped to %0d", $time,
			level_display));
	a_dwell_max: assert property (@(posedge clk) disable iff (!reset)
		open_run <= `DOOR_DWELL_CYCLES)
		else stop_run($sformatf("Error at %0t ns: door open too long", $time));
	a_open_then_close: assert property (@(posedge clk) disable iff (!reset)
		open_run != 0 && door != `DOOR_OPEN |-> door == `DOOR_CLOSE)
		else stop_run($sformatf("Error at %0t ns: open not followed by close", $time));
	a_close_btn: assert property (@(posedge clk) disable iff (!reset)
		open_run != 0 && door == `DOOR_OPEN && close_btn |=> door == `DOOR_CLOSE)
		else stop_run($sformatf("Error at %0t ns: close_btn ignored", $time));
	a_close_max: assert property (@(posedge clk) disable iff (!reset)
		close_run <= `DOOR_CLOSE_CYCLES)
		else stop_run($sformatf("Error at %0t ns: closing phase too long", $time));
	a_close_len: assert property (@(posedge clk) disable iff (!reset)
		close_run != 0 && door != `DOOR_CLOSE |->
		close_run == `DOOR_CLOSE_CYCLES || (door == `DOOR_OPEN && $past(open_btn)))
		else stop_run($sformatf("Error at %0t ns: closing phase cut short", $time));
	a_reopen: assert property (@(posedge clk) disable iff (!reset)
		door == `DOOR_CLOSE && open_btn |=> door == `DOOR_OPEN)
		else stop_run($sformatf("Error at %0t ns: open_btn did not reopen", $time));
	a_parked: assert property (@(posedge clk) disable iff (!reset)
		quiet_phase |-> engine == `ENGINE_IDLE)
		else stop_run($sformatf("Error at %0t ns: engine ran with no calls", $time));
	a_no_phantom: assert property (@(posedge clk) disable iff (!reset)
		invalid_stage |-> door == `DOOR_IDLE)
		else stop_run($sformatf("Error at %0t ns: missing hall button served", $time));
	a_open_wait: assert property (@(posedge clk) disable iff (!reset)
		open_wait <= 2)
		else stop_run($sformatf("Error at %0t ns: open_btn too slow when parked", $time));

	task automatic next_cycle;
		@(posedge clk);
		#1;
		open_btn     = 1'b0;
		close_btn    = 1'b0;
		btn_in       = '0;
		btn_up_out   = '0;
		btn_down_out = '0;
	endtask

	task automatic react_to_door;
		int r;
		if (door == `DOOR_CLOSE) begin
			take_bits(2, r);
			open_btn = (r == 0);
		end else if (door == `DOOR_OPEN) begin
			take_bits(3, r);
			close_btn = (r == 0);
		end
	endtask

	// idle gap followed by one press of a random button
	task automatic run_sequence;
		int gap;
		int fl;
		int kind;
		take_bits(4, gap);
		repeat (gap) begin
			next_cycle;
			react_to_door;
		end
		next_cycle;
		take_bits(3, fl);
		take_bits(2, kind);
		case (kind)
			0, 1: btn_in[fl] = 1'b1;
			2: btn_up_out[fl] = 1'b1;
			default: btn_down_out[fl] = 1'b1;
		endcase
		no_press_yet = 1'b0;
	endtask

	task automatic wait_until_idle;
		int idle_run;
		idle_run = 0;
		while (idle_run < 4) begin
			next_cycle;
			if (model_empty && engine == `ENGINE_IDLE && door == `DOOR_IDLE)
				idle_run++;
			else
				idle_run = 0;
		end
	endtask

	initial begin : stimulus
		lfsr          = 16'd62313;
		reset         = 1'b0;
		open_btn      = 1'b0;
		close_btn     = 1'b0;
		btn_in        = '0;
		btn_up_out    = '0;
		btn_down_out  = '0;
		no_press_yet  = 1'b1;
		quiet_phase   = 1'b0;
		invalid_stage = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b1;
		repeat (5) next_cycle;
		for (int s = 0; s < SEQUENCES; s++)
			run_sequence;
		wait_until_idle; // every call served
		quiet_phase   = 1'b1;
		invalid_stage = 1'b1;
		repeat (4) begin
			next_cycle;
			btn_up_out[`ELEV_FLOORS-1] = 1'b1;
			btn_down_out[0]            = 1'b1;
		end
		repeat (8) next_cycle;
		invalid_stage = 1'b0;
		next_cycle;
		open_btn = 1'b1;
		while (door != `DOOR_CLOSE)
			next_cycle;
		open_btn = 1'b1; // reopen while closing
		wait_until_idle;
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
